/* logic/irq_entry_cfg.svh */
`ifndef IRQ_ENTRY_CFG_SVH
`define IRQ_ENTRY_CFG_SVH

// bus cycle queue entries, also the starting credit count
`define IRQ_QUEUE_DEPTH 4

`define IRQ_STACK_PAGE  8'h01   // stack lives in page one
`define IRQ_VECTOR_BASE 12'hFFF // top nibble range of the vector table

`endif

/* logic/irq_types_pkg.sv */
`default_nettype none

package irq_types_pkg;

  // --------------------
  // interrupt sources
  // --------------------

  // listed in priority order, reset wins over nmi, nmi over irq
  typedef enum logic [1:0]
  {
    src_res = 2'd0, // power-on or external reset
    src_nmi = 2'd1, // falling edge on nmi
    src_irq = 2'd2  // unmasked low level on irq
  } irq_src_t;

endpackage

`default_nettype wire

/* logic/bus_types_pkg.sv */
`default_nettype none

package bus_types_pkg;

  // --------------------
  // bus cycle kinds
  // --------------------

  typedef enum logic [1:0]
  {
    kind_push   = 2'd0, // stack access
    kind_vec_lo = 2'd1, // vector low byte read
    kind_vec_hi = 2'd2  // vector high byte read
  } cycle_kind_t;

  // one memory access of the entry sequence
  typedef struct packed
  {
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        write;
    cycle_kind_t kind;
    logic        last;  // final cycle of a sequence
  } bus_cycle_t;

endpackage

`default_nettype wire

/* logic/cycle_link_if.sv */
`default_nettype none

// bus cycles flow downstream, credits flow back up
interface cycle_link_if;

  logic                      valid;  // cycle present this clock
  bus_types_pkg::bus_cycle_t cycle;
  logic                      credit; // one pulse per freed slot

  modport src
  (
    output valid,
    output cycle,
    input  credit
  );

  modport dst
  (
    input  valid,
    input  cycle,
    output credit
  );

  modport mon
  (
    input valid,
    input cycle,
    input credit
  );

endinterface

`default_nettype wire

/* logic/irq_control.sv */
`default_nettype none

`include "irq_entry_cfg.svh"

module irq_control
(
  input  wire logic                    I_clock,
  input  wire logic                    I_reset,
  input  wire logic                    I_nmi,
  input  wire logic                    I_irq,
  input  wire logic                    I_irq_mask,
  input  wire logic                    take,
  output logic                         force_brk,
  output logic                         O_irq_mask,
  output logic [15:0]                  vec_lo,
  output logic [15:0]                  vec_hi,
  output irq_types_pkg::irq_src_t      src
);

  logic       last_nmi;   // nmi sampled one clock ago
  logic       raise_nmi;  // falling edge seen
  logic       raise_res;  // set while in reset
  logic       raise_irq;
  logic       res_p;
  logic       nmi_p;
  logic       irq_p;
  logic       take_res;
  logic       take_nmi;
  logic       take_irq;
  logic [3:0] vec_nib;

  assign raise_irq  = ~I_irq & ~I_irq_mask; // level, active low
  assign force_brk  = res_p | nmi_p | irq_p;
  assign O_irq_mask = res_p | irq_p | I_irq_mask;

  assign take_res = take & (src == irq_types_pkg::src_res);
  assign take_nmi = take & (src == irq_types_pkg::src_nmi);
  assign take_irq = take & (src == irq_types_pkg::src_irq);

  // --------------------
  // priority and vectors
  // --------------------

  always_comb
  begin
    if (res_p)
    begin
      src     = irq_types_pkg::src_res;
      vec_nib = 4'hC;
    end
    else if (nmi_p)
    begin
      src     = irq_types_pkg::src_nmi;
      vec_nib = 4'hA;
    end
    else
    begin
      src     = irq_types_pkg::src_irq;
      vec_nib = 4'hE;
    end
  end

  assign vec_lo = {`IRQ_VECTOR_BASE, vec_nib};
  assign vec_hi = {`IRQ_VECTOR_BASE, vec_nib + 4'd1}; // pair is always lo+1

  // --------------------
  // pending latches
  // --------------------

  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
    begin
      last_nmi  <= 1'b0;
      raise_nmi <= 1'b0;
      raise_res <= 1'b1; // reset request waits for release
      res_p     <= 1'b0;
      nmi_p     <= 1'b0;
      irq_p     <= 1'b0;
    end
    else
    begin
      last_nmi  <= I_nmi;
      raise_nmi <= last_nmi & ~I_nmi;
      raise_res <= 1'b0;

      if (raise_res)
        res_p <= 1'b1;
      else if (take_res)
        res_p <= 1'b0;

      // a fresh edge beats the clear
      if (raise_nmi)
        nmi_p <= 1'b1;
      else if (take_nmi)
        nmi_p <= 1'b0;

      irq_p <= raise_irq & ~take_irq; // re-evaluated every clock
    end
  end

endmodule

`default_nettype wire

/* logic/entry_sequencer.sv */
`default_nettype none

`include "irq_entry_cfg.svh"

module entry_sequencer
(
  input  wire logic                     I_clock,
  input  wire logic                     I_reset,
  input  wire logic                     force_brk,
  input  wire logic [15:0]              vec_lo,
  input  wire logic [15:0]              vec_hi,
  input  wire irq_types_pkg::irq_src_t  src,
  output logic                          take,
  input  wire logic [15:0]              I_pc,
  input  wire logic [7:0]               I_status,
  input  wire logic [7:0]               I_sp,
  cycle_link_if.src                     link
);

  localparam int unsigned CRED_W  = $clog2(`IRQ_QUEUE_DEPTH + 1);
  localparam logic [7:0]  BRK_BIT = 8'h10;

  logic                      busy;
  logic [2:0]                step;     // 0..4 within a sequence
  logic [CRED_W-1:0]         credits;
  logic                      send;
  logic                      push_wr;
  logic [7:0]                sp_m1;
  logic [7:0]                sp_m2;
  bus_types_pkg::bus_cycle_t cyc;

  // values frozen at take
  logic [15:0]               pc_q;
  logic [7:0]                status_q;
  logic [7:0]                sp_q;
  logic [15:0]               vlo_q;
  logic [15:0]               vhi_q;
  irq_types_pkg::irq_src_t   src_q;

  assign take    = ~busy & force_brk;
  assign send    = busy & (credits != '0);
  assign push_wr = (src_q != irq_types_pkg::src_res); // reset only reads the stack
  assign sp_m1   = sp_q - 8'd1;
  assign sp_m2   = sp_q - 8'd2;

  // --------------------
  // cycle builder
  // --------------------

  always_comb
  begin
    cyc = '0;
    case (step)
      3'd0:
      begin
        cyc.addr  = {`IRQ_STACK_PAGE, sp_q};
        cyc.wdata = pc_q[15:8];
        cyc.write = push_wr;
        cyc.kind  = bus_types_pkg::kind_push;
      end
      3'd1:
      begin
        cyc.addr  = {`IRQ_STACK_PAGE, sp_m1};
        cyc.wdata = pc_q[7:0];
        cyc.write = push_wr;
        cyc.kind  = bus_types_pkg::kind_push;
      end
      3'd2:
      begin
        cyc.addr  = {`IRQ_STACK_PAGE, sp_m2};
        cyc.wdata = status_q & ~BRK_BIT; // hardware entry, not brk
        cyc.write = push_wr;
        cyc.kind  = bus_types_pkg::kind_push;
      end
      3'd3:
      begin
        cyc.addr = vlo_q;
        cyc.kind = bus_types_pkg::kind_vec_lo;
      end
      default:
      begin
        cyc.addr = vhi_q;
        cyc.kind = bus_types_pkg::kind_vec_hi;
        cyc.last = 1'b1;
      end
    endcase
  end

  assign link.valid = send;
  assign link.cycle = cyc;

  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
    begin
      busy    <= 1'b0;
      step    <= 3'd0;
      credits <= CRED_W'(`IRQ_QUEUE_DEPTH);
    end
    else
    begin
      credits <= credits - CRED_W'(send) + CRED_W'(link.credit);
      if (take)
      begin
        busy <= 1'b1;
        step <= 3'd0;
      end
      else if (send)
      begin
        step <= step + 3'd1;
        if (step == 3'd4)
          busy <= 1'b0; // fifth beat out
      end
    end
  end

  always_ff @(posedge I_clock)
  begin
    if (take)
    begin
      pc_q     <= I_pc;
      status_q <= I_status;
      sp_q     <= I_sp;
      vlo_q    <= vec_lo;
      vhi_q    <= vec_hi;
      src_q    <= src;
    end
  end

endmodule

`default_nettype wire

/* logic/cycle_queue.sv */
`default_nettype none

`include "irq_entry_cfg.svh"

module cycle_queue
(
  input  wire logic I_clock,
  input  wire logic I_reset,
  cycle_link_if.dst in_link,
  cycle_link_if.src out_link
);

  localparam int unsigned DEPTH = `IRQ_QUEUE_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  bus_types_pkg::bus_cycle_t mem [DEPTH];
  logic [PTR_W-1:0]          wr_ptr;
  logic [PTR_W-1:0]          rd_ptr;
  logic [CNT_W-1:0]          count;
  logic                      push;
  logic                      pop;

  // wraps for any depth, not only powers of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign push           = in_link.valid;   // credit scheme keeps us from overflowing
  assign pop            = out_link.credit; // engine completed the head
  assign out_link.valid = (count != '0);
  assign out_link.cycle = mem[rd_ptr];
  assign in_link.credit = pop;             // slot freed, hand it back

  always_ff @(posedge I_clock)
  begin
    if (push)
      mem[wr_ptr] <= in_link.cycle;
  end

  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (pop)
        rd_ptr <= ptr_inc(rd_ptr);
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

endmodule

`default_nettype wire

/* logic/bus_engine.sv */
`default_nettype none

module bus_engine
(
  input  wire logic        I_clock,
  input  wire logic        I_reset,
  cycle_link_if.dst        link,
  output logic             O_mem_valid,
  output logic             O_mem_write,
  output logic [15:0]      O_mem_addr,
  output logic [7:0]       O_mem_wdata,
  input  wire logic [7:0]  I_mem_rdata,
  input  wire logic        I_mem_ready,
  output logic             O_pc_load,
  output logic [15:0]      O_pc_new
);

  logic       complete;    // head cycle finishes this clock
  logic       is_vec_lo;
  logic       is_last;
  logic [7:0] vec_lo_byte;

  // --------------------
  // memory port
  // --------------------

  assign O_mem_valid = link.valid;
  assign O_mem_write = link.valid & link.cycle.write;
  assign O_mem_addr  = link.cycle.addr;
  assign O_mem_wdata = link.cycle.wdata;

  assign complete    = link.valid & I_mem_ready;
  assign link.credit = complete; // pops the queue head
  assign is_vec_lo   = complete & (link.cycle.kind == bus_types_pkg::kind_vec_lo);
  assign is_last     = complete & link.cycle.last;

  // --------------------
  // new program counter
  // --------------------

  always_ff @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
      O_pc_load <= 1'b0;
    else
      O_pc_load <= is_last; // one clock per entry
  end

  always_ff @(posedge I_clock)
  begin
    if (is_vec_lo)
      vec_lo_byte <= I_mem_rdata;
    if (is_last)
      O_pc_new <= {I_mem_rdata, vec_lo_byte}; // high byte arrives last
  end

endmodule

`default_nettype wire

/* logic/irq_entry_top.sv */
`default_nettype none

module irq_entry_top
(
  input  wire logic                I_clock,
  input  wire logic                I_reset,
  input  wire logic                I_nmi,
  input  wire logic                I_irq,
  input  wire logic                I_irq_mask,
  input  wire logic [15:0]         I_pc,
  input  wire logic [7:0]          I_status,
  input  wire logic [7:0]          I_sp,
  input  wire logic [7:0]          I_mem_rdata,
  input  wire logic                I_mem_ready,
  output logic                     O_irq_mask,
  output logic                     O_busy,
  output irq_types_pkg::irq_src_t  O_src,
  output logic                     O_mem_valid,
  output logic                     O_mem_write,
  output logic [15:0]              O_mem_addr,
  output logic [7:0]               O_mem_wdata,
  output logic                     O_pc_load,
  output logic [15:0]              O_pc_new
);

  logic                    force_brk;
  logic                    take;
  logic [15:0]             vec_lo;
  logic [15:0]             vec_hi;
  irq_types_pkg::irq_src_t src;

  cycle_link_if seq_link (); // sequencer to queue
  cycle_link_if eng_link (); // queue to engine

  assign O_busy = force_brk;
  assign O_src  = src;

  irq_control irq_control_inst
  (
    .I_clock    (I_clock),
    .I_reset    (I_reset),
    .I_nmi      (I_nmi),
    .I_irq      (I_irq),
    .I_irq_mask (I_irq_mask),
    .take       (take),
    .force_brk  (force_brk),
    .O_irq_mask (O_irq_mask),
    .vec_lo     (vec_lo),
    .vec_hi     (vec_hi),
    .src        (src)
  );

  entry_sequencer entry_sequencer_inst
  (
    .I_clock   (I_clock),
    .I_reset   (I_reset),
    .force_brk (force_brk),
    .vec_lo    (vec_lo),
    .vec_hi    (vec_hi),
    .src       (src),
    .take      (take),
    .I_pc      (I_pc),
    .I_status  (I_status),
    .I_sp      (I_sp),
    .link      (seq_link.src)
  );

  cycle_queue cycle_queue_inst
  (
    .I_clock  (I_clock),
    .I_reset  (I_reset),
    .in_link  (seq_link.dst),
    .out_link (eng_link.src)
  );

  bus_engine bus_engine_inst
  (
    .I_clock     (I_clock),
    .I_reset     (I_reset),
    .link        (eng_link.dst),
    .O_mem_valid (O_mem_valid),
    .O_mem_write (O_mem_write),
    .O_mem_addr  (O_mem_addr),
    .O_mem_wdata (O_mem_wdata),
    .I_mem_rdata (I_mem_rdata),
    .I_mem_ready (I_mem_ready),
    .O_pc_load   (O_pc_load),
    .O_pc_new    (O_pc_new)
  );

endmodule

`default_nettype wire

/* tests/irq_entry_checker.sv */
`default_nettype none

`include "irq_entry_cfg.svh"

module irq_entry_checker
(
  input  wire logic                    I_clock,
  input  wire logic                    I_reset,
  input  wire logic                    nmi,
  input  wire logic                    irq,
  input  wire logic                    mask,
  input  wire logic [15:0]             pc,
  input  wire logic [7:0]              status,
  input  wire logic [7:0]              sp,
  input  wire logic                    mem_ready,
  input  wire logic [47:0]             vectors,   // bytes of FFFA..FFFF, lowest first
  input  wire logic                    irq_mask,
  input  wire logic                    busy,
  input  wire irq_types_pkg::irq_src_t src,
  input  wire logic                    mem_valid,
  input  wire logic                    mem_write,
  input  wire logic [15:0]             mem_addr,
  input  wire logic [7:0]              mem_wdata,
  input  wire logic                    pc_load,
  input  wire logic [15:0]             pc_new,
  input  wire logic                    stop,
  output int                           entries,
  output int                           checks_total,
  output int                           errors_total
);

  typedef struct packed
  {
    logic [15:0] addr;
    logic        write;
    logic [7:0]  wdata;
    logic        last;
    int          test;  // which behavior this beat belongs to
  } beat_t;

  beat_t       beats [$];     // predicted bus cycles, oldest first
  logic [15:0] exp_pc [$];
  int          exp_pc_test [$];
  int          checks [1:5];
  int          errs [1:5];
  int          taken [3];     // entries started, per source
  int          err_count;
  int          miss_count = 0;
  logic        test1_done;
  int          k;
  int          t;

  // reference model state
  logic                    last_nmi;
  logic                    raise_nmi;
  logic                    raise_res;
  logic                    res_p;
  logic                    nmi_p;
  logic                    irq_p;
  logic                    busy_m;
  int                      sent;
  int                      credits;
  logic                    load_due;
  logic [15:0]             load_pc;
  int                      load_test;
  logic                    want;
  logic                    take;
  logic                    send;
  logic                    exp_valid;
  logic                    done;
  irq_types_pkg::irq_src_t pick;

  assign errors_total = err_count + miss_count;

  function automatic beat_t make_beat(input logic [15:0] addr, input logic write,
                                      input logic [7:0] wdata, input logic last, input int test);
    beat_t b;
    b.addr  = addr;
    b.write = write;
    b.wdata = wdata;
    b.last  = last;
    b.test  = test;
    return b;
  endfunction

  function automatic string test_name(input int n);
    case (n)
      1:       return "reset entry";
      2:       return "nmi entries";
      3:       return "irq entries";
      4:       return "push contents";
      default: return "order and pc load";
    endcase
  endfunction

  task automatic print_test(input int n);
    $display("test %0d %s: %0d checks, %0d errors", n, test_name(n), checks[n], errs[n]);
  endtask

  task automatic check_value(input int test, input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    checks[test]++;
    checks_total++;
    if (got !== exp)
    begin
      errs[test]++;
      err_count++;
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input int test, input string what);
    errs[test]++;
    err_count++;
    $display("error at %0t: %s", $time, what);
  endtask

  // --------------------
  // entry prediction
  // --------------------

  task automatic expect_entry(input irq_types_pkg::irq_src_t s);
    logic [15:0] lo_addr;
    logic        wr;
    int          idx;
    int          vtest;
    int          ptest;
    if (s == irq_types_pkg::src_res)
    begin
      lo_addr = 16'hFFFC;
      idx     = 2;
      vtest   = 1;
    end
    else if (s == irq_types_pkg::src_nmi)
    begin
      lo_addr = 16'hFFFA;
      idx     = 0;
      vtest   = 2;
    end
    else
    begin
      lo_addr = 16'hFFFE;
      idx     = 4;
      vtest   = 3;
    end
    wr    = (s != irq_types_pkg::src_res); // reset reads the stack instead
    ptest = wr ? 4 : 1;
    beats.push_back(make_beat({`IRQ_STACK_PAGE, sp}, wr, pc[15:8], 1'b0, ptest));
    beats.push_back(make_beat({`IRQ_STACK_PAGE, sp - 8'd1}, wr, pc[7:0], 1'b0, ptest));
    beats.push_back(make_beat({`IRQ_STACK_PAGE, sp - 8'd2}, wr, status & 8'hEF, 1'b0, ptest));
    beats.push_back(make_beat(lo_addr, 1'b0, 8'h00, 1'b0, vtest));
    beats.push_back(make_beat(lo_addr + 16'd1, 1'b0, 8'h00, 1'b1, vtest));
    exp_pc.push_back({vectors[8*idx+8 +: 8], vectors[8*idx +: 8]});
    exp_pc_test.push_back(vtest);
    taken[int'(s)]++;
  endtask

  task automatic check_beat();
    beat_t b;
    if (beats.size() == 0)
      report_failure(5, "bus cycle completed with no entry in progress");
    else
    begin
      b = beats.pop_front();
      check_value(b.test, "O_mem_addr", mem_addr, b.addr);
      check_value(b.test, "O_mem_write", 16'(mem_write), 16'(b.write));
      if (b.write)
        check_value(b.test, "O_mem_wdata", 16'(mem_wdata), 16'(b.wdata));
      if (b.last)
      begin
        load_due  = 1'b1;
        load_pc   = exp_pc.pop_front();
        load_test = exp_pc_test.pop_front();
      end
    end
  endtask

  task automatic check_load();
    if (load_due)
    begin
      check_value(5, "O_pc_load", 16'(pc_load), 16'd1);
      check_value(load_test, "O_pc_new", pc_new, load_pc);
      entries++;
      load_due = 1'b0;
      if (load_test == 1 && !test1_done)
      begin
        print_test(1);
        test1_done = 1'b1;
      end
    end
    else
      check_value(5, "O_pc_load", 16'(pc_load), 16'd0);
  endtask

  // --------------------
  // model and compare
  // --------------------

  always @(posedge I_clock or negedge I_reset)
  begin
    if (!I_reset)
    begin
      last_nmi   = 1'b0;
      raise_nmi  = 1'b0;
      raise_res  = 1'b1;
      res_p      = 1'b0;
      nmi_p      = 1'b0;
      irq_p      = 1'b0;
      busy_m     = 1'b0;
      sent       = 0;
      credits    = `IRQ_QUEUE_DEPTH;
      load_due   = 1'b0;
      load_pc    = 16'h0000;
      load_test  = 1;
      test1_done = 1'b0;
      entries    = 0;
      checks_total = 0;
      err_count  = 0;
      beats.delete();
      exp_pc.delete();
      exp_pc_test.delete();
      for (k = 1; k <= 5; k++)
      begin
        checks[k] = 0;
        errs[k]   = 0;
      end
      for (k = 0; k < 3; k++)
        taken[k] = 0;
    end
    else
    begin
      want = res_p | nmi_p | irq_p;
      if (res_p)
        pick = irq_types_pkg::src_res;
      else if (nmi_p)
        pick = irq_types_pkg::src_nmi;
      else
        pick = irq_types_pkg::src_irq;
      take      = !busy_m && want;
      send      = busy_m && (credits != 0);
      exp_valid = (credits != `IRQ_QUEUE_DEPTH); // every missing credit is a queued cycle
      done      = exp_valid && mem_ready;        // engine completes the head

      check_value(2, "O_busy", 16'(busy), 16'(want));
      if (want)
        check_value(2, "O_src", 16'(src), 16'(pick));
      check_value(3, "O_irq_mask", 16'(irq_mask), 16'(res_p | irq_p | mask));
      check_value(5, "O_mem_valid", 16'(mem_valid), 16'(exp_valid));
      check_load();
      if (done)
        check_beat();

      if (take)
      begin
        expect_entry(pick);
        busy_m = 1'b1;
        sent   = 0;
      end
      else if (send)
      begin
        sent++;
        if (sent == 5)
          busy_m = 1'b0;
      end
      if (send)
        credits--;
      if (done)
        credits++;

      if (raise_res)
        res_p = 1'b1;
      else if (take && pick == irq_types_pkg::src_res)
        res_p = 1'b0;
      if (raise_nmi)
        nmi_p = 1'b1;
      else if (take && pick == irq_types_pkg::src_nmi)
        nmi_p = 1'b0;
      irq_p     = !irq && !mask && !(take && pick == irq_types_pkg::src_irq);
      raise_nmi = last_nmi && !nmi; // falling edge
      last_nmi  = nmi;
      raise_res = 1'b0;
    end
  end

  always @(posedge stop)
  begin
    if (taken[int'(irq_types_pkg::src_nmi)] == 0)
    begin
      miss_count++;
      $display("error: no nmi entry was taken during the run");
    end
    if (taken[int'(irq_types_pkg::src_irq)] == 0)
    begin
      miss_count++;
      $display("error: no irq entry was taken during the run");
    end
    if (!test1_done)
      print_test(1);
    for (t = 2; t <= 5; t++)
      print_test(t);
  end

endmodule

`default_nettype wire

/* tests/irq_entry_tb.sv */
`default_nettype none

module irq_entry_tb;

  localparam int ENTRY_GOAL  = 60;
  localparam int CYCLE_LIMIT = ENTRY_GOAL * 40 + 200;

  logic                    I_clock;
  logic                    I_reset;
  logic                    nmi;
  logic                    irq;
  logic                    mask;
  logic [15:0]             pc;
  logic [7:0]              status;
  logic [7:0]              sp;
  logic [7:0]              mem_rdata;
  logic                    mem_ready;
  logic                    irq_mask;
  logic                    busy;
  irq_types_pkg::irq_src_t src;
  logic                    mem_valid;
  logic                    mem_write;
  logic [15:0]             mem_addr;
  logic [7:0]              mem_wdata;
  logic                    pc_load;
  logic [15:0]             pc_new;

  logic [7:0]  mem [65536];   // byte memory behind the bus port
  logic [47:0] vectors;
  logic [31:0] fill;
  logic        stop;
  integer      seed;
  int          cycles;
  int          entries;
  int          checks_total;
  int          errors_total;
  int          a;

  always #10 I_clock = ~I_clock;

  assign vectors = {mem[16'hFFFF], mem[16'hFFFE], mem[16'hFFFD],
                    mem[16'hFFFC], mem[16'hFFFB], mem[16'hFFFA]};

  // --------------------
  // stimulus
  // --------------------

  task automatic drive_random_inputs();
    logic [31:0] r;
    r = $random(seed);
    if (r[3:0] == 4'd0)
      nmi = ~nmi;
    r = $random(seed);
    if (r[2:0] == 3'd0)
      irq = ~irq;             // level held for a while
    r = $random(seed);
    mask = r[0];
    r = $random(seed);
    pc     = r[15:0];
    status = r[23:16];
    sp     = r[31:24];
    r = $random(seed);
    mem_ready = (r % 10) < 7; // ready about 70% of clocks
    if (mem_ready && mem_valid && mem_write)
      mem[mem_addr] = mem_wdata; // completes at the next rising edge
    mem_rdata = mem[mem_addr];
  endtask

  irq_entry_top irq_entry_top_inst
  (
    .I_clock     (I_clock),
    .I_reset     (I_reset),
    .I_nmi       (nmi),
    .I_irq       (irq),
    .I_irq_mask  (mask),
    .I_pc        (pc),
    .I_status    (status),
    .I_sp        (sp),
    .I_mem_rdata (mem_rdata),
    .I_mem_ready (mem_ready),
    .O_irq_mask  (irq_mask),
    .O_busy      (busy),
    .O_src       (src),
    .O_mem_valid (mem_valid),
    .O_mem_write (mem_write),
    .O_mem_addr  (mem_addr),
    .O_mem_wdata (mem_wdata),
    .O_pc_load   (pc_load),
    .O_pc_new    (pc_new)
  );

  irq_entry_checker irq_entry_checker_inst
  (
    .I_clock      (I_clock),
    .I_reset      (I_reset),
    .nmi          (nmi),
    .irq          (irq),
    .mask         (mask),
    .pc           (pc),
    .status       (status),
    .sp           (sp),
    .mem_ready    (mem_ready),
    .vectors      (vectors),
    .irq_mask     (irq_mask),
    .busy         (busy),
    .src          (src),
    .mem_valid    (mem_valid),
    .mem_write    (mem_write),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .pc_load      (pc_load),
    .pc_new       (pc_new),
    .stop         (stop),
    .entries      (entries),
    .checks_total (checks_total),
    .errors_total (errors_total)
  );

  initial
  begin
    seed      = 652;
    I_clock   = 1'b0;
    I_reset   = 1'b0;
    nmi       = 1'b1;
    irq       = 1'b1;
    mask      = 1'b1;
    pc        = 16'h0000;
    status    = 8'h00;
    sp        = 8'hFF;
    mem_rdata = 8'h00;
    mem_ready = 1'b0;
    stop      = 1'b0;
    cycles    = 0;
    for (a = 0; a < 65536; a++)
    begin
      fill   = $random(seed);
      mem[a] = fill[7:0];
    end

    repeat (4) @(negedge I_clock); // reset over four clocks
    I_reset = 1'b1;

    while (entries < ENTRY_GOAL && cycles < CYCLE_LIMIT)
    begin
      drive_random_inputs();
      @(negedge I_clock);
      cycles++;
    end

    stop = 1'b1;
    #1;
    if (cycles >= CYCLE_LIMIT)
      $display("run timed out after %0d cycles with %0d of %0d entries done",
               cycles, entries, ENTRY_GOAL);
    $display("entries %0d, checks %0d, errors %0d", entries, checks_total, errors_total);
    if (errors_total == 0 && cycles < CYCLE_LIMIT)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+logic
logic/irq_types_pkg.sv
logic/bus_types_pkg.sv
logic/cycle_link_if.sv
logic/irq_control.sv
logic/entry_sequencer.sv
logic/cycle_queue.sv
logic/bus_engine.sv
logic/irq_entry_top.sv
tests/irq_entry_checker.sv
tests/irq_entry_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -f list.f --top-module irq_entry_tb -o irq_entry_sim
	./obj_dir/irq_entry_sim > sim.log
	cat sim.log
	grep -qx "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
